// ==== project.f ====
rtl/fma16_pkg.sv
rtl/fp16_operand_if.sv
rtl/fma16_classify.sv
rtl/fma16_mul_align.sv
rtl/fma16_round.sv
rtl/fma16_special.sv
rtl/fma16_core.sv
rtl/fma16_apb_regs.sv
rtl/fma16_apb.sv
verification/fma16_assert.sv
verification/fma16_tb.sv

// ==== verification/fma16_tb.sv ====
/*
  fma16 testbench
  APB driven directed vectors with hand computed results,
  protocol error cases, watchdog and summary
*/

`timescale 1ns/1ps

module fma16_tb import fma16_pkg::*; ();

    typedef struct packed {
        logic [15:0] x, y, z;
        logic [5:0]  ctrl;  // mul add negp negz rne go
        logic [15:0] res;
        logic [2:0]  flg;   // nv of nx
    } vec_t;

    logic        clk, rst, psel, penable, pwrite, pready, pslverr;
    logic [4:0]  paddr;
    logic [31:0] pwdata, prdata, rd;
    logic        err;
    vec_t        vecs[$];
    int          err_cnt = 0;

    fma16_apb DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns
    end

    ////////////////////////////////////////////////////
    // helpers
    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // setup then access phase with the read back taken mid access
    task automatic apb_xfer(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #25;
        rdata  = prdata;
        slverr = pslverr;
        @(posedge clk);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            psel    = 1'b0;
            penable = 1'b0;
        end
    endtask

    task automatic add_vector(input logic [15:0] x, y, z, input logic [5:0] ctrl,
                              input logic [15:0] res, input logic [2:0] flg);
        vecs.push_back('{x, y, z, ctrl, res, flg});
    endtask

    task automatic run_vector(input vec_t v);
        logic [4:0]  addr [3];
        logic [15:0] data [3];
        logic [4:0]  ta;
        logic [15:0] td;
        int          i, j;
        addr = '{reg_x, reg_y, reg_z};
        data = '{v.x, v.y, v.z};
        for (i = 2; i > 0; i--) begin  // shuffle operand write order
            j       = $urandom_range(i, 0);
            ta      = addr[i];
            addr[i] = addr[j];
            addr[j] = ta;
            td      = data[i];
            data[i] = data[j];
            data[j] = td;
        end
        for (i = 0; i < 3; i++) begin
            apb_xfer(1'b1, addr[i], {16'b0, data[i]}, rd, err);
            idle($urandom_range(1, 0));
        end
        apb_xfer(1'b1, reg_ctrl, {26'b0, v.ctrl}, rd, err);
        rd = '0;
        while (!rd[31])  // poll until done is set
            apb_xfer(1'b0, reg_result, '0, rd, err);
        check("result", rd[15:0], v.res);
        check("flags", rd[18:16], v.flg);
    endtask

    ////////////////////////////////////////////////////
    // main sequence
    initial begin
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        void'($urandom(32'h19ab_d799));
        add_vector(16'h3e00, 16'h4000, 16'h3400, 6'b000011, 16'h4280, 3'b000);  // 1.5*2+0.25
        add_vector(16'h4200, 16'hc000, 16'h0000, 6'b100011, 16'hc600, 3'b000);  // mul 3*-2
        add_vector(16'h3e00, 16'h0000, 16'h3400, 6'b010011, 16'h3f00, 3'b000);  // add
        add_vector(16'h4200, 16'h0000, 16'h3400, 6'b010111, 16'h4180, 3'b000);  // sub 3-0.25
        add_vector(16'h3c00, 16'h3c00, 16'h1000, 6'b000011, 16'h3c00, 3'b001);  // tie to even
        add_vector(16'h3c00, 16'h3c00, 16'h1000, 6'b000001, 16'h3c00, 3'b001);
        add_vector(16'h3c00, 16'h3c00, 16'h1200, 6'b000011, 16'h3c01, 3'b001);  // above half
        add_vector(16'h3c00, 16'h3c00, 16'h1200, 6'b000001, 16'h3c00, 3'b001);
        add_vector(16'h2200, 16'h2600, 16'h3c00, 6'b001011, 16'h3bff, 3'b001);  // near 1.0
        add_vector(16'h7bff, 16'h4000, 16'h0000, 6'b100011, 16'h7c00, 3'b011);  // overflow rne
        add_vector(16'h7bff, 16'h4000, 16'h0000, 6'b100001, 16'h7bff, 3'b011);  // overflow rtz
        add_vector(16'h7e00, 16'h3c00, 16'h0000, 6'b000011, 16'h7e00, 3'b000);  // qnan in
        add_vector(16'h7d00, 16'h3c00, 16'h0000, 6'b000011, 16'h7e00, 3'b100);  // snan in
        add_vector(16'h7c00, 16'h0000, 16'h0000, 6'b000011, 16'h7e00, 3'b100);  // inf*0
        add_vector(16'h7c00, 16'h0000, 16'hfc00, 6'b010011, 16'h7e00, 3'b100);  // inf-inf
        add_vector(16'h8000, 16'h3c00, 16'h8000, 6'b000011, 16'h8000, 3'b000);  // -0 + -0
        add_vector(16'h3c00, 16'h4000, 16'h4000, 6'b000111, 16'h0000, 3'b000);  // fmsub to +0
        add_vector(16'h3c00, 16'h4000, 16'hc000, 6'b001111, 16'h0000, 3'b000);  // fnmadd to +0
        add_vector(16'h3c00, 16'h4000, 16'h4000, 6'b001011, 16'h0000, 3'b000);  // fnmsub to +0
        add_vector(16'h3e00, 16'h4000, 16'h3400, 6'b001111, 16'hc280, 3'b000);  // fnmadd
        add_vector(16'h3e00, 16'h4000, 16'h3400, 6'b001011, 16'hc180, 3'b000);  // fnmsub
        add_vector(16'h3e00, 16'h4000, 16'h3400, 6'b000111, 16'h4180, 3'b000);  // fmsub

        // an unmapped access completes on the third and last reset edge
        @(posedge clk);
        apb_xfer(1'b1, 5'h14, 32'h1234, rd, err);
        check("pslverr", err, 1'b0);
        @(negedge clk);
        rst     = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;

        apb_xfer(1'b0, reg_result, '0, rd, err);
        check("prdata after reset", rd, 32'h0);
        // launch on zero operands and read done on the very next transfer
        apb_xfer(1'b1, reg_ctrl, 32'h0000_0001, rd, err);
        apb_xfer(1'b0, reg_result, '0, rd, err);
        check("done", rd[31], 1'b1);
        check("pslverr", err, 1'b0);

        foreach (vecs[k])
            run_vector(vecs[k]);

        // unmapped offset written then read
        apb_xfer(1'b1, 5'h14, 32'h1234, rd, err);
        check("pslverr", err, 1'b1);
        apb_xfer(1'b0, 5'h14, '0, rd, err);
        check("pslverr", err, 1'b1);
        // result register is read only
        apb_xfer(1'b1, reg_result, 32'hffff_ffff, rd, err);
        check("pslverr", err, 1'b1);
        apb_xfer(1'b0, reg_result, '0, rd, err);
        check("prdata", rd, {1'b1, 12'b0, vecs[$].flg, vecs[$].res});
        idle(2);

        $display("check errors: %0d, assertion errors: %0d", err_cnt, DUT.u_assert.fail_cnt);
        if (err_cnt == 0 && DUT.u_assert.fail_cnt == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // watchdog sized from the vector count
    initial begin
        @(negedge rst);
        repeat (vecs.size() * 20 + 50) @(posedge clk);
        $display("timeout: run did not complete in time");
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== verification/fma16_assert.sv ====
/*
  fma16 APB protocol and timing assertions
  bound into the top level, watches go pulse, done and reset values
*/

`timescale 1ns/1ps

module fma16_assert import fma16_pkg::*; (
    input logic          clk,
    input logic          rst,
    input logic          psel,
    input logic          penable,
    input logic          pwrite,
    input logic [4:0]    paddr,
    input logic [31:0]   pwdata,
    input logic          pready,
    input logic          pslverr,
    input logic          start,
    input logic          done,
    input fma16_flags_t  flags
);

    int   fail_cnt = 0;  // read by the testbench summary
    logic go_wr;         // accepted ctrl write with go set

    assign go_wr = psel & penable & pwrite & (paddr == reg_ctrl) & pwdata[0];

    ////////////////////////////////////////////////////
    // APB side
    a_pready: assert property (@(posedge clk) pready)
        else begin fail_cnt++; $error("pready dropped"); end

    a_rst_err: assert property (@(posedge clk) rst |-> !pslverr)
        else begin fail_cnt++; $error("pslverr high in reset"); end

    ////////////////////////////////////////////////////
    // launch and completion
    a_start_src: assert property (@(posedge clk) disable iff (rst) start |-> $past(go_wr))
        else begin fail_cnt++; $error("start without a go write"); end

    a_go_start: assert property (@(posedge clk) disable iff (rst) go_wr |=> start)
        else begin fail_cnt++; $error("go write gave no start"); end

    a_done_rise: assert property (@(posedge clk) disable iff (rst) $rose(done) |-> $past(start))
        else begin fail_cnt++; $error("done rose without start"); end

    a_done_lat: assert property (@(posedge clk) disable iff (rst) start |=> done)
        else begin fail_cnt++; $error("done late after start"); end

    // registered outputs cleared by the reset edge
    a_rst_val: assert property (@(posedge clk) rst |=> (!done && flags == '0))
        else begin fail_cnt++; $error("done or flags set in reset"); end

endmodule

bind fma16_apb fma16_assert u_assert (
    .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
    .pready, .pslverr, .start, .done, .flags
);

// ==== rtl/fma16_apb.sv ====
/*
  fma16 with APB slave port
  top level, register block driving the fma16 core
*/

`timescale 1ns/1ps

module fma16_apb import fma16_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         psel,
    input  logic         penable,
    input  logic         pwrite,
    input  logic [4:0]   paddr,
    input  logic [31:0]  pwdata,
    output logic [31:0]  prdata,
    output logic         pready,
    output logic         pslverr
);

    logic [15:0]   x, y, z;     // operand registers
    fma16_ctrl_t   ctrl;
    logic          start;       // go pulse
    logic [15:0]   result;
    fma16_flags_t  flags;
    logic          done;

    fma16_apb_regs u_regs (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
        .result, .flags, .done,
        .prdata, .pready, .pslverr,
        .x, .y, .z, .ctrl, .start
    );

    fma16_core u_core (
        .clk, .rst, .x, .y, .z, .ctrl, .start,
        .result, .flags, .done
    );

endmodule

// ==== rtl/fma16_apb_regs.sv ====
/*
  fma16 APB register block
  operand and control registers, go pulse, result readback
  and address error detection, zero wait states
*/

`timescale 1ns/1ps

module fma16_apb_regs import fma16_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          psel,
    input  logic          penable,
    input  logic          pwrite,
    input  logic [4:0]    paddr,
    input  logic [31:0]   pwdata,
    input  logic [15:0]   result,
    input  fma16_flags_t  flags,
    input  logic          done,
    output logic [31:0]   prdata,
    output logic          pready,
    output logic          pslverr,
    output logic [15:0]   x,
    output logic [15:0]   y,
    output logic [15:0]   z,
    output fma16_ctrl_t   ctrl,
    output logic          start
);

    logic         access;   // access phase
    logic         addr_ok;
    logic         wr;       // accepted write
    fma16_ctrl_t  wr_ctrl;

    assign access  = psel & penable;
    assign pready  = 1'b1;
    assign wr_ctrl = fma16_ctrl_t'(pwdata[$bits(fma16_ctrl_t)-1:0]);

    ////////////////////////////////////////////////////
    // decode and read mux
    always_comb begin
        addr_ok = 1'b1;
        prdata  = '0;
        case (paddr)
            reg_x:      prdata = {16'b0, x};
            reg_y:      prdata = {16'b0, y};
            reg_z:      prdata = {16'b0, z};
            reg_ctrl:   prdata = {26'b0, ctrl};
            reg_result: prdata = {done, 12'b0, flags, result};  // nv in bit 18
            default:    addr_ok = 1'b0;
        endcase
    end

    // result is read only, no error response while in reset
    assign pslverr = access & ~rst & (~addr_ok | (pwrite & (paddr == reg_result)));
    assign wr      = access & pwrite & ~pslverr;

    ////////////////////////////////////////////////////
    // register writes
    always_ff @(posedge clk) begin
        if (rst) begin
            x     <= '0;
            y     <= '0;
            z     <= '0;
            ctrl  <= '0;
            start <= 1'b0;
        end else begin
            start <= wr & (paddr == reg_ctrl) & wr_ctrl.go;  // one cycle pulse
            if (wr) begin
                case (paddr)
                    reg_x:    x    <= pwdata[15:0];
                    reg_y:    y    <= pwdata[15:0];
                    reg_z:    z    <= pwdata[15:0];
                    reg_ctrl: ctrl <= wr_ctrl;
                    default:  ;
                endcase
            end
        end
    end

endmodule

// ==== rtl/fma16_core.sv ====
/*
  fma16 core
  operation controls, classify / align / round / special datapath
  and the one-cycle result register with done
*/

`timescale 1ns/1ps

module fma16_core import fma16_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic [15:0]   x,
    input  logic [15:0]   y,
    input  logic [15:0]   z,
    input  fma16_ctrl_t   ctrl,
    input  logic          start,
    output logic [15:0]   result,
    output fma16_flags_t  flags,
    output logic          done
);

    logic [15:0]           y_eff, z_eff;     // after mul / add forcing
    logic [sum_w-1:0]      sum;
    logic                  sum_sign, sticky;
    logic signed [6:0]     sum_exp;
    logic [15:0]           rounded, result_c;
    logic                  of, nx, prod_sign;
    fma16_flags_t          flags_c;

    fp16_operand_if op_x ();
    fp16_operand_if op_y ();
    fp16_operand_if op_z ();

    // add uses y = 1.0, mul uses z = -0 so a signed zero product keeps its sign
    assign y_eff = ctrl.add ? {1'b0, 5'(exp_bias), 10'b0} : y;
    assign z_eff = ctrl.mul ? {1'b1, 15'b0} : z;
    assign prod_sign = op_x.sign ^ op_y.sign ^ ctrl.negp;

    fma16_classify u_cls_x (.word(x),     .op(op_x));
    fma16_classify u_cls_y (.word(y_eff), .op(op_y));
    fma16_classify u_cls_z (.word(z_eff), .op(op_z));

    fma16_mul_align u_align (
        .opx(op_x), .opy(op_y), .opz(op_z),
        .negp(ctrl.negp), .negz(ctrl.negz),
        .sum, .sum_sign, .sum_exp, .sticky
    );

    fma16_round u_round (.sum, .sum_sign, .sum_exp, .sticky, .rne(ctrl.rne), .rounded, .of, .nx);

    fma16_special u_special (
        .opx(op_x), .opy(op_y), .opz(op_z),
        .rounded, .of, .nx, .prod_sign, .negz(ctrl.negz),
        .result(result_c), .flags(flags_c)
    );

    // capture on start, done holds until the next launch
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
            flags  <= '0;
            done   <= 1'b0;
        end else if (start) begin
            result <= result_c;
            flags  <= flags_c;
            done   <= 1'b1;
        end
    end

endmodule

// ==== rtl/fma16_special.sv ====
/*
  fma16 special value override
  NaN, infinity and zero rules applied over the rounded result
*/

`timescale 1ns/1ps

module fma16_special import fma16_pkg::*; (
    fp16_operand_if.dst     opx,
    fp16_operand_if.dst     opy,
    fp16_operand_if.dst     opz,
    input  logic [15:0]     rounded,
    input  logic            of,
    input  logic            nx,
    input  logic            prod_sign,   // already includes negp
    input  logic            negz,
    output logic [15:0]     result,
    output fma16_flags_t    flags
);

    logic z_sign;
    logic any_nan, any_snan;
    logic prod_inf, inf_zero, inf_cancel;
    logic exact_zero;

    assign z_sign   = opz.sign ^ negz;
    assign any_nan  = opx.is_nan | opy.is_nan | opz.is_nan;
    assign any_snan = opx.is_snan | opy.is_snan | opz.is_snan;

    assign prod_inf   = opx.is_inf | opy.is_inf;
    assign inf_zero   = (opx.is_inf & opy.is_zero) | (opy.is_inf & opx.is_zero);
    assign inf_cancel = prod_inf & opz.is_inf & (prod_sign ^ z_sign);  // inf - inf
    assign exact_zero = (rounded[14:0] == '0) & ~nx;

    always_comb begin
        result = rounded;
        flags  = '0;
        if (any_nan) begin
            result   = qnan_val;
            flags.nv = any_snan;
        end else if (inf_zero | inf_cancel) begin
            result   = qnan_val;
            flags.nv = 1'b1;
        end else if (prod_inf) begin
            result = prod_sign ? neg_inf : pos_inf;
        end else if (opz.is_inf) begin
            result = z_sign ? neg_inf : pos_inf;
        end else if (exact_zero) begin
            result = {prod_sign & z_sign, 15'b0};  // -0 only from -0 + -0
        end else begin
            flags.of = of;
            flags.nx = nx;
        end
    end

endmodule

// ==== rtl/fma16_round.sv ====
/*
  fma16 normalize and round
  leading zero count, shift, round toward zero or nearest even,
  overflow to inf or max_norm and flush of tiny results
*/

`timescale 1ns/1ps

module fma16_round import fma16_pkg::*; (
    input  logic [sum_w-1:0]   sum,
    input  logic               sum_sign,
    input  logic signed [6:0]  sum_exp,
    input  logic               sticky,
    input  logic               rne,
    output logic [15:0]        rounded,
    output logic               of,
    output logic               nx
);

    logic [5:0]            lz;
    logic [sum_w-1:0]      norm;     // msb at top
    logic [man_w:0]        mant;     // kept bits incl hidden one
    logic                  guard, st, inc;
    logic [man_w+1:0]      mant_r;   // carry out on top
    logic signed [8:0]     e, e_f;

    // leading zeros, highest set bit wins
    always_comb begin
        lz = '0;
        for (int i = 0; i < sum_w; i++) begin
            if (sum[i])
                lz = 6'(sum_w - 1 - i);
        end
    end

    assign norm  = sum << lz;
    assign mant  = norm[sum_w-1 -: man_w+1];
    assign guard = norm[sum_w-man_w-2];
    assign st    = (|norm[sum_w-man_w-3:0]) | sticky;

    // bit 22 carries sum_exp, msb at 35 - lz, hence +13
    assign e = $signed({{2{sum_exp[6]}}, sum_exp}) + 9'sd13 - $signed({3'b0, lz});

    assign inc    = rne & guard & (st | mant[0]);  // ties to even
    assign mant_r = {1'b0, mant} + {{(man_w+1){1'b0}}, inc};
    assign e_f    = e + $signed({8'b0, mant_r[man_w+1]});  // 1.111.. rolled over

    ////////////////////////////////////////////////////
    // range checks
    always_comb begin
        rounded = {sum_sign, e_f[exp_w-1:0], mant_r[man_w-1:0]};
        of      = 1'b0;
        nx      = guard | st;
        if (sum == '0) begin
            rounded = {sum_sign, 15'b0};  // sign fixed later by special rules
            nx      = sticky;
        end else if (e_f >= 9'sd31) begin
            of      = 1'b1;
            nx      = 1'b1;
            rounded = rne ? {sum_sign, pos_inf[14:0]} : {sum_sign, max_norm[14:0]};
        end else if (e_f <= 9'sd0) begin
            rounded = {sum_sign, 15'b0};  // below smallest normal
            nx      = 1'b1;
        end
    end

endmodule

// ==== rtl/fma16_mul_align.sv ====
/*
  fma16 multiply and align stage
  forms x*y, places the addend next to it in a 36-bit window,
  then adds or subtracts and returns the magnitude with its sign
*/

`timescale 1ns/1ps

module fma16_mul_align import fma16_pkg::*; (
    fp16_operand_if.dst        opx,
    fp16_operand_if.dst        opy,
    fp16_operand_if.dst        opz,
    input  logic               negp,
    input  logic               negz,
    output logic [sum_w-1:0]   sum,
    output logic               sum_sign,
    output logic signed [6:0]  sum_exp,   // biased exponent of window bit 22
    output logic               sticky
);

    logic [man_w:0]        mx, my, mz;    // significands with hidden bit
    logic [2*man_w+1:0]    pm;            // product, point at bit 20
    logic signed [7:0]     pe, ez, d;
    logic                  p_sign, z_sign, sub;
    logic                  z_only;        // product only matters as sticky
    logic                  z_big;
    logic [6:0]            zsh;
    logic [2*sum_w-1:0]    z_wide;        // upper half is the window
    logic [sum_w-1:0]      p_vec, z_vec;
    logic                  p_sticky, z_sticky;

    ////////////////////////////////////////////////////
    // product
    assign mx = opx.is_zero ? '0 : {1'b1, opx.man};
    assign my = opy.is_zero ? '0 : {1'b1, opy.man};
    assign mz = opz.is_zero ? '0 : {1'b1, opz.man};
    assign pm = mx * my;
    assign pe = $signed({3'b0, opx.exp}) + $signed({3'b0, opy.exp}) - 8'(exp_bias);
    assign ez = $signed({3'b0, opz.exp});
    assign d  = ez - pe;  // addend exponent above product

    assign p_sign = opx.sign ^ opy.sign ^ negp;
    assign z_sign = opz.sign ^ negz;
    assign sub    = p_sign ^ z_sign;

    // zero product, or addend too far above it for the window
    assign z_only = opx.is_zero | opy.is_zero | ((d > 8'sd13) & ~opz.is_zero);

    ////////////////////////////////////////////////////
    // alignment
    // product point sits at bit 22, addend lsb lands at 12 + d
    assign p_vec    = z_only ? '0 : {{(sum_w-2*man_w-4){1'b0}}, pm, 2'b00};
    assign p_sticky = z_only & (|pm);

    assign zsh    = z_only ? 7'd1 : 7'(8'sd13 - d);  // 0..57
    assign z_wide = {mz, {(2*sum_w-man_w-1){1'b0}}} >> zsh;
    assign z_vec  = z_wide[2*sum_w-1:sum_w];
    assign z_sticky = |z_wide[sum_w-1:0];  // bits shifted past the window

    assign sticky  = p_sticky | z_sticky;  // at most one side is truncated
    assign sum_exp = z_only ? 7'(ez - 8'sd12) : 7'(pe);

    ////////////////////////////////////////////////////
    // add or subtract
    assign z_big = z_vec > p_vec;

    always_comb begin
        if (!sub) begin
            sum      = p_vec + z_vec;  // room above, no carry out
            sum_sign = p_sign;
        end else if (z_big) begin
            // truncated side is the smaller one, borrow one lsb for it
            sum      = z_vec - p_vec - {{(sum_w-1){1'b0}}, sticky};
            sum_sign = z_sign;
        end else begin
            sum      = p_vec - z_vec - {{(sum_w-1){1'b0}}, sticky};
            sum_sign = p_sign;
        end
    end

endmodule

// ==== rtl/fma16_classify.sv ====
/*
  fp16 operand classifier
  splits a half-precision word into fields and tags zero, inf and NaN
*/

`timescale 1ns/1ps

module fma16_classify import fma16_pkg::*; (
    input  logic [15:0]  word,
    fp16_operand_if.src  op
);

    logic exp_ones;   // exponent all ones
    logic exp_zeros;  // exponent all zeros
    logic man_nz;

    assign exp_ones  = &word[exp_w+man_w-1 -: exp_w];
    assign exp_zeros = ~|word[exp_w+man_w-1 -: exp_w];
    assign man_nz    = |word[man_w-1:0];

    // raw fields
    assign op.sign = word[15];
    assign op.exp  = word[exp_w+man_w-1 -: exp_w];
    assign op.man  = word[man_w-1:0];

    // subnormals have no support here, they count as zero
    assign op.is_zero = exp_zeros;
    assign op.is_inf  = exp_ones & ~man_nz;
    assign op.is_nan  = exp_ones & man_nz;
    assign op.is_snan = exp_ones & man_nz & ~word[man_w-1];  // quiet bit clear

endmodule

// ==== rtl/fp16_operand_if.sv ====
/*
  fp16 operand bundle
  one classified half-precision operand, classifier to datapath
*/

`timescale 1ns/1ps

interface fp16_operand_if import fma16_pkg::*; ();
    logic             sign;
    logic [exp_w-1:0] exp;
    logic [man_w-1:0] man;
    logic             is_zero;  // includes flushed subnormals
    logic             is_inf;
    logic             is_nan;
    logic             is_snan;

    modport src (output sign, exp, man, is_zero, is_inf, is_nan, is_snan);
    modport dst (input  sign, exp, man, is_zero, is_inf, is_nan, is_snan);
endinterface

// ==== rtl/fma16_pkg.sv ====
/*
  fma16 shared definitions
  half-precision format widths, special encodings, APB register map
  and the control and flag structs used across the design
*/

package fma16_pkg;

    // binary16 format
    localparam int exp_w    = 5;
    localparam int man_w    = 10;
    localparam int exp_bias = 15;
    localparam int sum_w    = 36;  // product + guard bits + addend room on either side

    // special encodings
    localparam logic [15:0] qnan_val = 16'h7e00;  // quiet, mantissa msb set
    localparam logic [15:0] pos_inf  = 16'h7c00;
    localparam logic [15:0] neg_inf  = 16'hfc00;
    localparam logic [15:0] max_norm = 16'h7bff;  // largest finite magnitude

    // APB register offsets
    localparam logic [4:0] reg_x      = 5'h00;
    localparam logic [4:0] reg_y      = 5'h04;
    localparam logic [4:0] reg_z      = 5'h08;
    localparam logic [4:0] reg_ctrl   = 5'h0c;
    localparam logic [4:0] reg_result = 5'h10;

    // control word, go sits in bit 0
    typedef struct packed {
        logic mul;   // z forced to zero
        logic add;   // y forced to one
        logic negp;  // negate product
        logic negz;  // negate addend
        logic rne;   // 1 nearest even, 0 toward zero
        logic go;    // launch
    } fma16_ctrl_t;

    typedef struct packed {
        logic nv;  // invalid
        logic of;  // overflow
        logic nx;  // inexact
    } fma16_flags_t;

endpackage
